//--- verilog/io_pkg.sv
/*
  I/O package
  word-addressed register map of the extended I/O section,
  bus widths and the bit layout of the error signal vector
*/

package io_pkg;

  // ----------------------------------------------------------
  // bus geometry
  // ----------------------------------------------------------
  localparam int io_addr_w = 6;   // word address, byte address bits 7..2
  localparam int io_data_w = 32;  // bus data
  localparam int sp_w      = 24;  // stack pointer and pc

  // ----------------------------------------------------------
  // register map, word addresses within the 64-word I/O space
  // ----------------------------------------------------------
  // ms timer, one word at -64
  localparam logic [io_addr_w-1:0] addr_tmr = 6'h30;
  // sys control and status at -72
  // word 0 is cause/control, word 1 is error address
  localparam logic [io_addr_w-1:0] addr_scs = 6'h2E;
  // stack monitor at -96
  // limit, hot zone, low-water mark, current sp
  localparam logic [io_addr_w-1:0] addr_stm = 6'h28;
  // watchdog, one word at -112
  localparam logic [io_addr_w-1:0] addr_wd  = 6'h24;

  // ----------------------------------------------------------
  // error signal vector
  // ----------------------------------------------------------
  localparam int err_w = 8;
  // bit 0 reserved for the kill button, not fitted here
  localparam int err_idx_wd      = 1;  // watchdog timeout
  localparam int err_idx_stm_lim = 2;  // stack below limit
  localparam int err_idx_stm_hot = 3;  // stack in hot zone

endpackage

//--- verilog/ms_timer.sv
/*
  Millisecond timer
  divides the clock down to a one-cycle ms tick and counts
  milliseconds since the last system reset; read only
*/

`timescale 1ns/10ps

module ms_timer import io_pkg::*; #(
  parameter int clock_freq = 50_000_000  // Hz
) (
  input  logic                 clk,
  input  logic                 sys_rst,  // active low
  input  logic                 stb,
  output logic [io_data_w-1:0] rdata,
  output logic                 ack,
  output logic                 ms_tick   // one pulse per ms
);

  localparam int div_max = clock_freq / 1000 - 1;  // last divider state
  localparam int div_w   = $clog2(div_max + 2);

  logic [div_w-1:0]     div;     // cycles within current ms
  logic [io_data_w-1:0] ms_cnt;  // running milliseconds

  // ----------------------------------------------------------
  // divider and counter
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!sys_rst) begin
      div     <= '0;
      ms_tick <= 1'b0;
      ms_cnt  <= '0;
    end else begin
      ms_tick <= 1'b0;
      if (div == div_w'(div_max)) begin
        div     <= '0;
        ms_tick <= 1'b1;                 // wrap, fire tick
      end else begin
        div <= div + div_w'(1);
      end
      if (ms_tick) ms_cnt <= ms_cnt + io_data_w'(1);
    end
  end

  // ack survives sys_rst, writes just get acked
  always_ff @(posedge clk) begin
    ack <= stb & ~ack;
  end

  assign rdata = ms_cnt;

endmodule

//--- verilog/watchdog.sv
/*
  Watchdog
  a write loads a timeout in ms and arms it, zero disarms;
  the count runs down on ms ticks and trig rises at zero,
  holding until the next write or system reset
*/

`timescale 1ns/10ps

module watchdog import io_pkg::*; (
  input  logic                 clk,
  input  logic                 sys_rst,  // active low
  input  logic                 stb,
  input  logic                 we,
  input  logic [15:0]          wdata,    // timeout, ms
  input  logic                 ms_tick,
  output logic [io_data_w-1:0] rdata,
  output logic                 ack,
  output logic                 trig
);

  logic [15:0] timeout;  // programmed value, read back
  logic [15:0] cnt;      // remaining ms
  logic        armed;
  logic        wr;

  assign wr = stb & we & ~ack;  // first strobe cycle only

  // ----------------------------------------------------------
  // countdown
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!sys_rst) begin
      timeout <= '0;
      cnt     <= '0;
      armed   <= 1'b0;
      trig    <= 1'b0;
    end else if (wr) begin
      // service: reload, rearm, drop any pending trigger
      timeout <= wdata;
      cnt     <= wdata;
      armed   <= (wdata != 16'd0);
      trig    <= 1'b0;
    end else if (armed && ms_tick) begin
      cnt <= cnt - 16'd1;
      if (cnt == 16'd1) begin
        trig  <= 1'b1;   // expired
        armed <= 1'b0;   // one shot until serviced
      end
    end
  end

  always_ff @(posedge clk) begin
    ack <= stb & ~ack;   // not touched by sys_rst
  end

  assign rdata = {16'b0, timeout};

endmodule

//--- verilog/stack_mon.sv
/*
  Stack monitor
  compares the cpu stack pointer against a limit and a
  hot-zone bound, each active when nonzero, and records
  the lowest stack pointer seen (low-water mark)
*/

`timescale 1ns/10ps

module stack_mon import io_pkg::*; (
  input  logic                 clk,
  input  logic                 sys_rst,  // active low
  input  logic                 stb,
  input  logic                 we,
  input  logic [1:0]           sel,      // word within block
  input  logic [sp_w-1:0]      wdata,
  input  logic [sp_w-1:0]      sp,       // live cpu stack pointer
  output logic [io_data_w-1:0] rdata,
  output logic                 ack,
  output logic                 trig_lim,
  output logic                 trig_hot
);

  logic [sp_w-1:0] lim;  // hard limit, 0 = off
  logic [sp_w-1:0] hot;  // hot-zone bound, 0 = off
  logic [sp_w-1:0] lwm;  // lowest sp so far
  logic            wr;

  assign wr = stb & we & ~ack;

  // ----------------------------------------------------------
  // registers
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!sys_rst) begin
      lim <= '0;
      hot <= '0;
      lwm <= '1;                           // anything is lower
    end else begin
      if (wr && sel == 2'd0) lim <= wdata;
      if (wr && sel == 2'd1) begin
        hot <= wdata;
        lwm <= sp;                         // new watch period starts here
      end else if (sp < lwm) begin
        lwm <= sp;
      end
    end
  end

  always_ff @(posedge clk) begin
    ack <= stb & ~ack;                     // only the bus handshake
  end

  // ----------------------------------------------------------
  // comparators, levels follow sp directly
  // ----------------------------------------------------------
  assign trig_lim = (lim != '0) && (sp < lim);
  assign trig_hot = (hot != '0) && (sp < hot);

  // read mux
  always_comb begin
    case (sel)
      2'd0:    rdata = {{(io_data_w-sp_w){1'b0}}, lim};
      2'd1:    rdata = {{(io_data_w-sp_w){1'b0}}, hot};
      2'd2:    rdata = {{(io_data_w-sp_w){1'b0}}, lwm};
      default: rdata = {{(io_data_w-sp_w){1'b0}}, sp};   // current sp
    endcase
  end

endmodule

//--- verilog/sys_ctrl.sv
/*
  System control and status
  watches the error signals for rising edges, latches the
  first cause and the faulting pc, and pulses the system
  reset of the other I/O blocks for a fixed number of cycles
*/

`timescale 1ns/10ps

module sys_ctrl import io_pkg::*; #(
  parameter int restart_cycles = 4  // sys_rst low time after an error
) (
  input  logic                 clk,
  input  logic                 rst_n,     // external reset only
  input  logic                 stb,
  input  logic                 we,
  input  logic                 sel,       // 0 cause/ctrl, 1 error addr
  input  logic [io_data_w-1:0] wdata,
  input  logic [err_w-1:0]     err_sig,   // level triggers
  input  logic [sp_w-1:0]      err_addr,  // cpu pc
  output logic [io_data_w-1:0] rdata,
  output logic                 ack,
  output logic                 sys_rst    // active low
);

  localparam int cnt_w = $clog2(restart_cycles + 1);

  logic [err_w-1:0] err_prev;   // for edge detection
  logic [err_w-1:0] err_rise;
  logic [7:0]       cause;      // bit index + 1, 0 = none
  logic [7:0]       new_cause;
  logic [sp_w-1:0]  err_pc;     // pc at time of error
  logic [cnt_w-1:0] rst_cnt;    // remaining reset cycles
  logic             wr;

  assign wr       = stb & we & ~ack;
  assign err_rise = err_sig & ~err_prev;

  // lowest bit wins when several rise together
  always_comb begin
    new_cause = 8'd0;
    for (int i = err_w - 1; i >= 0; i--) begin
      if (err_rise[i]) new_cause = 8'(i + 1);
    end
  end

  // ----------------------------------------------------------
  // cause latch and restart sequencing
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      err_prev <= '0;
      cause    <= '0;
      err_pc   <= '0;
      rst_cnt  <= cnt_w'(restart_cycles - 1);  // hold sys reset past rst_n
      sys_rst  <= 1'b0;
      ack      <= 1'b0;
    end else begin
      ack      <= stb & ~ack;
      err_prev <= err_sig;

      // count down, release when done
      if (rst_cnt != '0) rst_cnt <= rst_cnt - cnt_w'(1);
      else               sys_rst <= 1'b1;

      if (wr && sel) err_pc <= wdata[sp_w-1:0];   // sw may preset/clear

      if (wr && !sel) begin
        cause <= '0;                              // clear, rearm latching
      end else if (cause == 8'd0 && new_cause != 8'd0) begin
        // first error only, later ones wait for a clear
        cause   <= new_cause;
        err_pc  <= err_addr;
        rst_cnt <= cnt_w'(restart_cycles - 1);
        sys_rst <= 1'b0;                          // restart the peripherals
      end
    end
  end

  // read mux
  assign rdata = sel ? {{(io_data_w-sp_w){1'b0}}, err_pc}
                     : {24'b0, cause};

endmodule

//--- verilog/io_top.sv
/*
  Extended I/O section
  strobe decoding for ms timer, watchdog, stack monitor and
  system control, read data and ack muxing, plus a responder
  that acks unmapped addresses with zero data
*/

`timescale 1ns/10ps

module io_top import io_pkg::*; #(
  parameter int clock_freq     = 50_000_000,  // Hz
  parameter int restart_cycles = 4            // sys reset pulse length
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 stb,
  input  logic                 we,
  input  logic [io_addr_w-1:0] addr,
  input  logic [io_data_w-1:0] wdata,
  input  logic [sp_w-1:0]      sp,          // cpu stack pointer
  input  logic [sp_w-1:0]      pc,          // cpu pc, for error address
  output logic [io_data_w-1:0] rdata,
  output logic                 ack,
  output logic                 sys_rst      // active low
);

  logic tmr_stb, wd_stb, stm_stb, scs_stb, un_stb;
  logic tmr_ack, wd_ack, stm_ack, scs_ack;
  logic un_ack;                              // unmapped responder
  logic [io_data_w-1:0] tmr_rdata, wd_rdata, stm_rdata, scs_rdata;
  logic ms_tick;
  logic wd_trig, stm_trig_lim, stm_trig_hot;
  logic [err_w-1:0] err_sig;

  // ----------------------------------------------------------
  // address decoding
  // ----------------------------------------------------------
  assign tmr_stb = stb && (addr == addr_tmr);
  assign wd_stb  = stb && (addr == addr_wd);
  assign scs_stb = stb && (addr[io_addr_w-1:1] == addr_scs[io_addr_w-1:1]); // 2 words
  assign stm_stb = stb && (addr[io_addr_w-1:2] == addr_stm[io_addr_w-1:2]); // 4 words
  assign un_stb  = stb && !(tmr_stb || wd_stb || scs_stb || stm_stb);

  // nobody home, answer anyway so the master never hangs
  always_ff @(posedge clk) begin
    if (!rst_n) un_ack <= 1'b0;
    else        un_ack <= un_stb & ~un_ack;  // single ack per strobe
  end

  // error vector, order fixed by the index constants
  always_comb begin
    err_sig                  = '0;
    err_sig[err_idx_wd]      = wd_trig;
    err_sig[err_idx_stm_lim] = stm_trig_lim;
    err_sig[err_idx_stm_hot] = stm_trig_hot;
  end

  // ----------------------------------------------------------
  // peripherals
  // ----------------------------------------------------------
  ms_timer #(.clock_freq(clock_freq)) tmr_0 (
    .clk(clk), .sys_rst(sys_rst), .stb(tmr_stb),
    .rdata(tmr_rdata), .ack(tmr_ack), .ms_tick(ms_tick)
  );

  watchdog wd_0 (
    .clk(clk), .sys_rst(sys_rst), .stb(wd_stb), .we(we),
    .wdata(wdata[15:0]), .ms_tick(ms_tick),
    .rdata(wd_rdata), .ack(wd_ack), .trig(wd_trig)
  );

  stack_mon stm_0 (
    .clk(clk), .sys_rst(sys_rst), .stb(stm_stb), .we(we),
    .sel(addr[1:0]), .wdata(wdata[sp_w-1:0]), .sp(sp),
    .rdata(stm_rdata), .ack(stm_ack),
    .trig_lim(stm_trig_lim), .trig_hot(stm_trig_hot)
  );

  // runs on rst_n only, so the cause outlives the restart
  sys_ctrl #(.restart_cycles(restart_cycles)) scs_0 (
    .clk(clk), .rst_n(rst_n), .stb(scs_stb), .we(we),
    .sel(addr[0]), .wdata(wdata), .err_sig(err_sig), .err_addr(pc),
    .rdata(scs_rdata), .ack(scs_ack), .sys_rst(sys_rst)
  );

  // ----------------------------------------------------------
  // read data and ack muxing
  // ----------------------------------------------------------
  assign rdata = tmr_stb ? tmr_rdata :
                 wd_stb  ? wd_rdata  :
                 stm_stb ? stm_rdata :
                 scs_stb ? scs_rdata :
                 '0;                      // unmapped reads zero

  assign ack = tmr_stb ? tmr_ack :
               wd_stb  ? wd_ack  :
               stm_stb ? stm_ack :
               scs_stb ? scs_ack :
               un_ack;

endmodule

//--- verif/tb_clkgen.sv
/*
  Testbench clock and reset
  free-running clock, rst_n held low for the first few cycles
*/

`timescale 1ns/10ps

module tb_clkgen #(
  parameter int period     = 20,  // ns
  parameter int rst_cycles = 3
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (rst_cycles) @(posedge clk);
    #1 rst_n = 1'b1;  // release in the drive slot
  end

endmodule

//--- verif/io_props.sv
/*
  Bus and reset properties of the I/O section
  bound into io_top, failures counted in fail_cnt
*/

`timescale 1ns/10ps

module io_props (
  input logic clk,
  input logic rst_n,
  input logic stb,
  input logic ack,
  input logic sys_rst
);

  int fail_cnt = 0;  // read by the testbench at the end

  // every ack answers a strobe from the cycle before
  ack_follows_stb: assert property (@(posedge clk) disable iff (!rst_n)
    ack |-> $past(stb))
    else begin
      fail_cnt++;
      $error("ack without a strobe in the previous cycle");
    end

  // one ack per strobe
  ack_single: assert property (@(posedge clk) disable iff (!rst_n)
    ack |=> !ack)
    else begin
      fail_cnt++;
      $error("ack high for two cycles in a row");
    end

  // external reset forces the system reset
  rst_forces_sys_rst: assert property (@(posedge clk) !rst_n |=> !sys_rst)
    else begin
      fail_cnt++;
      $error("sys_rst high while rst_n low");
    end

endmodule

bind io_top io_props i_props (
  .clk(clk), .rst_n(rst_n), .stb(stb), .ack(ack), .sys_rst(sys_rst)
);

//--- verif/io_tb.sv
/*
  Testbench of the extended I/O section
  LFSR driven bus accesses against a register model: readback,
  timer progress, watchdog and stack restarts, cause clearing
*/

`timescale 1ns/10ps

module io_tb import io_pkg::*; ();

  localparam int restart_len = 4;
  localparam int xfer_cycles = 4;  // one access plus idle cycle
  localparam int test_cycles = 16 + 8 * 6 * xfer_cycles            // readback
                             + 4 * (2 * xfer_cycles + 20 + 255)    // timer
                             + (10 * 8 + 12 + 6 * xfer_cycles)     // watchdog
                             + (8 * xfer_cycles + 16 + 12)         // stack
                             + 12 * xfer_cycles;                   // clear, unmapped
  localparam int max_cycles  = 2 * test_cycles;

  logic        clk, rst_n, stb, we, ack, sys_rst;
  logic [5:0]  addr;
  logic [31:0] wdata, rdata;
  logic [23:0] sp, pc;
  logic [15:0] lfsr = 16'd71;  // seed
  int          cycle_cnt = 0, sample_cyc = 0;
  int          err_cnt = 0, chk_cnt = 0;
  // register model
  logic [15:0] m_wd;
  logic [23:0] m_lim, m_hot, m_lwm, m_eaddr;
  logic [7:0]  m_cause;

  tb_clkgen #(.period(20), .rst_cycles(3)) i_clkgen (.clk(clk), .rst_n(rst_n));

  io_top #(.clock_freq(10_000), .restart_cycles(restart_len)) i_dut (
    .clk(clk), .rst_n(rst_n), .stb(stb), .we(we), .addr(addr), .wdata(wdata),
    .sp(sp), .pc(pc), .rdata(rdata), .ack(ack), .sys_rst(sys_rst)
  );

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  // ----------------------------------------------------------
  // random bits, x^16+x^14+x^13+x^11+1
  // ----------------------------------------------------------
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);   // one step per bit
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [31:0] act,
                             input logic [31:0] exp);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  // ----------------------------------------------------------
  // bus master
  // ----------------------------------------------------------
  task automatic transfer(input logic [5:0] a, input logic w, input logic [31:0] wd,
                          output logic [31:0] rd);
    int wait_n;
    @(posedge clk);
    #1;
    stb    = 1'b1;
    we     = w;
    addr   = a;
    wdata  = wd;
    wait_n = 0;
    @(negedge clk);                       // ack still low here
    while (ack !== 1'b1 && wait_n < 16) begin
      @(negedge clk);
      wait_n++;
    end
    rd         = rdata;
    sample_cyc = cycle_cnt;
    if (ack !== 1'b1) begin
      err_cnt++;
      $display("no ack from word address %h after 16 cycles", a);
    end else begin
      check_value("ack_latency", wait_n, 1);
    end
    @(posedge clk);
    #1;
    stb = 1'b0;                           // drop in the cycle after ack
    we  = 1'b0;
  endtask

  task automatic write_reg(input logic [5:0] a, input logic [31:0] d);
    logic [31:0] dummy;
    transfer(a, 1'b1, d, dummy);
  endtask

  task automatic read_reg(input logic [5:0] a, output logic [31:0] d);
    transfer(a, 1'b0, '0, d);
  endtask

  // waits for sys_rst to fall and checks its low time
  task automatic wait_restart(input int limit);
    int fall_n;
    int low_n;
    fall_n = 0;
    low_n  = 0;
    @(negedge clk);
    while (sys_rst === 1'b1 && fall_n < limit) begin
      @(negedge clk);
      fall_n++;
    end
    if (sys_rst !== 1'b0) begin
      err_cnt++;
      $display("sys_rst did not fall within %0d cycles", limit);
    end else begin
      while (sys_rst === 1'b0 && low_n < 32) begin
        @(negedge clk);
        low_n++;
      end
      check_value("sys_rst_low_cycles", low_n, restart_len);
    end
    m_wd  = '0;                           // peripherals back at reset values
    m_lim = '0;
    m_hot = '0;
    @(posedge clk);
    #1;
  endtask

  function automatic bit is_mapped(input logic [5:0] a);
    return (a == addr_tmr) || (a == addr_wd) ||
           (a >= addr_scs && a <= addr_scs + 6'd1) ||
           (a >= addr_stm && a <= addr_stm + 6'd3);
  endfunction

  // ----------------------------------------------------------
  // tests
  // ----------------------------------------------------------
  initial begin
    logic [31:0] r, v, r0, r1;
    logic [5:0]  a;
    int          c0, k, lo, t;
    stb   = 1'b0;
    we    = 1'b0;
    addr  = '0;
    wdata = '0;
    sp    = 24'hFF_FFFF;                  // far above any bound
    pc    = 24'h00_1000;
    m_cause = '0;
    @(posedge rst_n);
    k = 0;
    while (sys_rst !== 1'b1 && k < 16) begin
      @(negedge clk);
      k++;
    end
    if (sys_rst !== 1'b1) begin
      err_cnt++;
      $display("sys_rst stayed low after reset release");
    end

    // register readback, wd timeout kept long
    for (int i = 0; i < 8; i++) begin
      v = rand_bits(32) | 32'h0000_8000;
      write_reg(addr_wd, v);
      m_wd = v[15:0];
      read_reg(addr_wd, r);
      check_value("wd_timeout", r, {16'b0, m_wd});
      v = rand_bits(32);
      write_reg(addr_stm, v);
      m_lim = v[23:0];
      read_reg(addr_stm, r);
      check_value("stm_limit", r, {8'b0, m_lim});
      v = rand_bits(32);
      write_reg(addr_stm + 6'd1, v);
      m_hot = v[23:0];
      read_reg(addr_stm + 6'd1, r);
      check_value("stm_hot", r, {8'b0, m_hot});
    end
    write_reg(addr_wd, '0);               // disarm
    m_wd = '0;
    read_reg(addr_scs, r);
    check_value("scs_cause", r, {24'b0, m_cause});

    // timer progress over random gaps
    for (int i = 0; i < 4; i++) begin
      read_reg(addr_tmr, r0);
      c0 = sample_cyc;
      repeat (20 + rand_bits(8)) @(posedge clk);
      read_reg(addr_tmr, r1);
      k  = sample_cyc - c0;
      lo = k / 10;                        // 10 cycles per ms
      // tick phase unknown, so one extra ms is allowed
      check_value("tmr_ms_delta_in_range",
                  32'((r1 - r0 == lo) || (r1 - r0 == lo + 1)), 32'd1);
    end

    // watchdog left unserviced
    v  = rand_bits(24);
    pc = v[23:0] | 24'h1;
    t  = 1 + rand_bits(3);
    write_reg(addr_wd, t);
    wait_restart(10 * t + 12);
    m_cause  = 8'(err_idx_wd + 1);
    m_eaddr  = pc;
    read_reg(addr_scs, r);
    check_value("scs_cause", r, {24'b0, m_cause});
    read_reg(addr_scs + 6'd1, r);
    check_value("scs_err_addr", r, {8'b0, m_eaddr});
    read_reg(addr_wd, r);
    check_value("wd_timeout", r, {16'b0, m_wd});

    // stack low-water mark, then a limit violation
    write_reg(addr_scs, '0);
    m_cause = '0;
    read_reg(addr_scs, r);
    check_value("scs_cause", r, {24'b0, m_cause});
    m_lim = 24'h10_0000;
    m_hot = 24'h40_0000;
    write_reg(addr_stm, {8'b0, m_lim});
    write_reg(addr_stm + 6'd1, {8'b0, m_hot});
    m_lwm = sp;                           // mark restarts at the hot write
    for (int i = 0; i < 16; i++) begin
      @(posedge clk);
      #1;
      v  = rand_bits(23);
      sp = {1'b1, v[22:0]};               // stays above the hot zone
      if (sp < m_lwm) m_lwm = sp;
    end
    read_reg(addr_stm + 6'd2, r);
    check_value("stm_low_water", r, {8'b0, m_lwm});
    read_reg(addr_stm + 6'd3, r);
    check_value("stm_sp", r, {8'b0, sp});
    v  = rand_bits(24);
    pc = v[23:0];
    v  = rand_bits(8);
    sp = m_lim - 24'd1 - v[23:0];         // below limit and hot zone
    wait_restart(12);
    m_cause = 8'(err_idx_stm_lim + 1);    // lowest bit wins
    m_eaddr = pc;
    sp      = 24'hFF_FFFF;
    read_reg(addr_scs, r);
    check_value("scs_cause", r, {24'b0, m_cause});
    read_reg(addr_scs + 6'd1, r);
    check_value("scs_err_addr", r, {8'b0, m_eaddr});
    read_reg(addr_stm, r);
    check_value("stm_limit", r, {8'b0, m_lim});

    // cause clearing and unmapped reads
    write_reg(addr_scs, '0);
    m_cause = '0;
    read_reg(addr_scs, r);
    check_value("scs_cause", r, {24'b0, m_cause});
    for (int i = 0; i < 8; i++) begin
      do begin
        v = rand_bits(6);
        a = v[5:0];
      end while (is_mapped(a));
      read_reg(a, r);
      check_value("unmapped_rdata", r, '0);
    end

    @(posedge clk);
    $display("checks: %0d  errors: %0d  assertion failures: %0d",
             chk_cnt, err_cnt, i_dut.i_props.fail_cnt);
    if (err_cnt == 0 && i_dut.i_props.fail_cnt == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

  // run limit
  initial begin
    while (cycle_cnt < max_cycles) @(posedge clk);
    $display("timeout: run stopped after %0d cycles", max_cycles);
    $display("Some tests failed");
    $finish;
  end

endmodule

//--- io_top.f
verilog/io_pkg.sv
verilog/ms_timer.sv
verilog/watchdog.sv
verilog/stack_mon.sv
verilog/sys_ctrl.sv
verilog/io_top.sv
verif/tb_clkgen.sv
verif/io_props.sv
verif/io_tb.sv

//--- run_sim.sh
#!/bin/sh
# Verilator build and run of the io_top testbench

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module io_tb -f io_top.f -o io_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/io_sim +verilator+error+limit+100 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^All tests passed$" "$log"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
